// ==== axi_arbiter.sv ====
`timescale 1ns/100ps

module axi_arbiter (
  input  logic   clock,
  input  logic   reset,
  axi_rd_if.slv  ifu_i,
  axi_rd_if.slv  exu_rd_i,
  axi_wr_if.slv  exu_wr_i,
  axi_rd_if.mst  mem_rd_o,
  axi_wr_if.mst  mem_wr_o,
  axi_rd_if.mst  clint_rd_o
);

  logic [axi_pkg::ST_W-1:0] state;
  logic [axi_pkg::ST_W-1:0] next_state;
  logic in_clint;
  logic ifu_g;
  logic exu_g;
  logic clint_g;
  logic wr_g;
  logic mem_r_done;
  logic clint_r_done;
  logic b_done;

  assign in_clint = (exu_rd_i.araddr >= soc_map_pkg::CLINT_BASE) &&
                    (exu_rd_i.araddr <= soc_map_pkg::CLINT_LAST);

  assign ifu_g   = (state == axi_pkg::ARB_IFU_RD);
  assign exu_g   = (state == axi_pkg::ARB_EXU_RD);
  assign clint_g = (state == axi_pkg::ARB_CLINT_RD);
  assign wr_g    = (state == axi_pkg::ARB_EXU_WR);

  // Granted readies are routed, so these only fire for the owner.
  assign mem_r_done   = mem_rd_o.rvalid && mem_rd_o.rready && mem_rd_o.rlast;
  assign clint_r_done = clint_rd_o.rvalid && clint_rd_o.rready && clint_rd_o.rlast;
  assign b_done       = mem_wr_o.bvalid && mem_wr_o.bready;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= axi_pkg::ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      axi_pkg::ARB_IDLE: begin
        if (ifu_i.arvalid) begin
          next_state = axi_pkg::ARB_IFU_RD;
        end else if (exu_rd_i.arvalid) begin
          next_state = in_clint ? axi_pkg::ARB_CLINT_RD : axi_pkg::ARB_EXU_RD;
        end else if (exu_wr_i.awvalid) begin
          next_state = axi_pkg::ARB_EXU_WR;
        end
      end
      axi_pkg::ARB_IFU_RD:   if (mem_r_done) next_state = axi_pkg::ARB_IFU_RD_POST;
      axi_pkg::ARB_EXU_RD:   if (mem_r_done) next_state = axi_pkg::ARB_EXU_RD_POST;
      axi_pkg::ARB_CLINT_RD: if (clint_r_done) next_state = axi_pkg::ARB_CLINT_RD_POST;
      axi_pkg::ARB_EXU_WR:   if (b_done) next_state = axi_pkg::ARB_EXU_WR_POST;
      default:               next_state = axi_pkg::ARB_IDLE; // POST states.
    endcase
  end

  // SRAM read port shared by IFU and non-CLINT EXU reads.
  assign mem_rd_o.arvalid = (ifu_g & ifu_i.arvalid) | (exu_g & exu_rd_i.arvalid);
  assign mem_rd_o.araddr  = ifu_g ? ifu_i.araddr  : exu_g ? exu_rd_i.araddr  : '0;
  assign mem_rd_o.arid    = ifu_g ? ifu_i.arid    : exu_g ? exu_rd_i.arid    : '0;
  assign mem_rd_o.arlen   = ifu_g ? ifu_i.arlen   : exu_g ? exu_rd_i.arlen   : '0;
  assign mem_rd_o.arsize  = ifu_g ? ifu_i.arsize  : exu_g ? exu_rd_i.arsize  : '0;
  assign mem_rd_o.arburst = ifu_g ? ifu_i.arburst : exu_g ? exu_rd_i.arburst : '0;
  assign mem_rd_o.rready  = (ifu_g & ifu_i.rready) | (exu_g & exu_rd_i.rready);

  assign clint_rd_o.arvalid = clint_g & exu_rd_i.arvalid;
  assign clint_rd_o.araddr  = clint_g ? exu_rd_i.araddr  : '0;
  assign clint_rd_o.arid    = clint_g ? exu_rd_i.arid    : '0;
  assign clint_rd_o.arlen   = clint_g ? exu_rd_i.arlen   : '0;
  assign clint_rd_o.arsize  = clint_g ? exu_rd_i.arsize  : '0;
  assign clint_rd_o.arburst = clint_g ? exu_rd_i.arburst : '0;
  assign clint_rd_o.rready  = clint_g & exu_rd_i.rready;

  assign ifu_i.arready = ifu_g & mem_rd_o.arready;
  assign ifu_i.rvalid  = ifu_g & mem_rd_o.rvalid;
  assign ifu_i.rdata   = ifu_g ? mem_rd_o.rdata : '0;
  assign ifu_i.rresp   = ifu_g ? mem_rd_o.rresp : '0;
  assign ifu_i.rlast   = ifu_g & mem_rd_o.rlast;
  assign ifu_i.rid     = ifu_g ? mem_rd_o.rid : '0;

  // EXU reads come back from either slave.
  assign exu_rd_i.arready = (exu_g & mem_rd_o.arready) | (clint_g & clint_rd_o.arready);
  assign exu_rd_i.rvalid  = (exu_g & mem_rd_o.rvalid) | (clint_g & clint_rd_o.rvalid);
  assign exu_rd_i.rdata   = exu_g ? mem_rd_o.rdata : clint_g ? clint_rd_o.rdata : '0;
  assign exu_rd_i.rresp   = exu_g ? mem_rd_o.rresp : clint_g ? clint_rd_o.rresp : '0;
  assign exu_rd_i.rlast   = (exu_g & mem_rd_o.rlast) | (clint_g & clint_rd_o.rlast);
  assign exu_rd_i.rid     = exu_g ? mem_rd_o.rid : clint_g ? clint_rd_o.rid : '0;

  assign mem_wr_o.awvalid = wr_g & exu_wr_i.awvalid;
  assign mem_wr_o.awaddr  = wr_g ? exu_wr_i.awaddr  : '0;
  assign mem_wr_o.awid    = wr_g ? exu_wr_i.awid    : '0;
  assign mem_wr_o.awlen   = wr_g ? exu_wr_i.awlen   : '0;
  assign mem_wr_o.awsize  = wr_g ? exu_wr_i.awsize  : '0;
  assign mem_wr_o.awburst = wr_g ? exu_wr_i.awburst : '0;
  assign mem_wr_o.wvalid  = wr_g & exu_wr_i.wvalid;
  assign mem_wr_o.wdata   = wr_g ? exu_wr_i.wdata : '0;
  assign mem_wr_o.wstrb   = wr_g ? exu_wr_i.wstrb : '0;
  assign mem_wr_o.wlast   = wr_g & exu_wr_i.wlast;
  assign mem_wr_o.bready  = wr_g & exu_wr_i.bready;

  assign exu_wr_i.awready = wr_g & mem_wr_o.awready;
  assign exu_wr_i.wready  = wr_g & mem_wr_o.wready;
  assign exu_wr_i.bvalid  = wr_g & mem_wr_o.bvalid;
  assign exu_wr_i.bresp   = wr_g ? mem_wr_o.bresp : '0;
  assign exu_wr_i.bid     = wr_g ? mem_wr_o.bid : '0;

endmodule

// ==== axi_ifs.sv ====
`timescale 1ns/100ps

interface axi_rd_if;
  logic                         arvalid;
  logic                         arready;
  logic [axi_pkg::ADDR_W-1:0]   araddr;
  logic [axi_pkg::ID_W-1:0]     arid;
  logic [axi_pkg::LEN_W-1:0]    arlen;
  logic [axi_pkg::SIZE_W-1:0]   arsize;
  logic [axi_pkg::BURST_W-1:0]  arburst;
  logic                         rvalid;
  logic                         rready;
  logic [axi_pkg::DATA_W-1:0]   rdata;
  logic [axi_pkg::RESP_W-1:0]   rresp;
  logic                         rlast;
  logic [axi_pkg::ID_W-1:0]     rid;

  modport mst (output arvalid, araddr, arid, arlen, arsize, arburst, rready,
               input  arready, rvalid, rdata, rresp, rlast, rid);
  modport slv (input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
               output arready, rvalid, rdata, rresp, rlast, rid);
endinterface

interface axi_wr_if;
  logic                         awvalid;
  logic                         awready;
  logic [axi_pkg::ADDR_W-1:0]   awaddr;
  logic [axi_pkg::ID_W-1:0]     awid;
  logic [axi_pkg::LEN_W-1:0]    awlen;
  logic [axi_pkg::SIZE_W-1:0]   awsize;
  logic [axi_pkg::BURST_W-1:0]  awburst;
  logic                         wvalid;
  logic                         wready;
  logic [axi_pkg::DATA_W-1:0]   wdata;
  logic [axi_pkg::STRB_W-1:0]   wstrb;
  logic                         wlast;
  logic                         bvalid;
  logic                         bready;
  logic [axi_pkg::RESP_W-1:0]   bresp;
  logic [axi_pkg::ID_W-1:0]     bid;

  modport mst (output awvalid, awaddr, awid, awlen, awsize, awburst,
                      wvalid, wdata, wstrb, wlast, bready,
               input  awready, wready, bvalid, bresp, bid);
  modport slv (input  awvalid, awaddr, awid, awlen, awsize, awburst,
                      wvalid, wdata, wstrb, wlast, bready,
               output awready, wready, bvalid, bresp, bid);
endinterface

// ==== axi_pkg.sv ====
package axi_pkg;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 64;
  localparam int STRB_W  = DATA_W / 8;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01; // Only type the SRAM implements.

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Arbiter grant states. Each grant is followed by its own POST state.
  localparam int ST_W = 4;

  localparam logic [ST_W-1:0] ARB_IDLE          = 4'd0;
  localparam logic [ST_W-1:0] ARB_IFU_RD        = 4'd1;
  localparam logic [ST_W-1:0] ARB_EXU_RD        = 4'd2;
  localparam logic [ST_W-1:0] ARB_CLINT_RD      = 4'd3;
  localparam logic [ST_W-1:0] ARB_EXU_WR        = 4'd4;
  localparam logic [ST_W-1:0] ARB_IFU_RD_POST   = 4'd5;
  localparam logic [ST_W-1:0] ARB_EXU_RD_POST   = 4'd6;
  localparam logic [ST_W-1:0] ARB_CLINT_RD_POST = 4'd7;
  localparam logic [ST_W-1:0] ARB_EXU_WR_POST   = 4'd8;

endpackage

// ==== axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram (
  input  logic   clock,
  input  logic   reset,
  axi_rd_if.slv  rd_i,
  axi_wr_if.slv  wr_i
);

  logic [axi_pkg::DATA_W-1:0]       mem [soc_map_pkg::SRAM_WORDS];
  logic [soc_map_pkg::SRAM_IDX_W-1:0] rd_idx;
  logic [soc_map_pkg::SRAM_IDX_W-1:0] wr_idx;
  logic [axi_pkg::LEN_W-1:0]        rd_left;
  logic                             wr_busy;
  logic                             busy;

  // One busy flag covers both since reads and writes never overlap.
  assign busy = rd_i.rvalid | wr_busy | wr_i.bvalid;

  assign rd_i.arready = !busy;
  assign wr_i.awready = !busy;
  assign wr_i.wready  = wr_busy;

  assign rd_i.rdata = mem[rd_idx];
  assign rd_i.rresp = axi_pkg::RESP_OKAY;
  assign rd_i.rlast = rd_i.rvalid && (rd_left == '0);
  assign wr_i.bresp = axi_pkg::RESP_OKAY;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      rd_i.rvalid <= 1'b0;
      wr_busy     <= 1'b0;
      wr_i.bvalid <= 1'b0;
      rd_idx      <= '0;
      rd_left     <= '0;
      wr_idx      <= '0;
    end else begin
      if (rd_i.arvalid && rd_i.arready) begin
        rd_i.rvalid <= 1'b1;
        rd_idx      <= rd_i.araddr[soc_map_pkg::SRAM_IDX_LSB +: soc_map_pkg::SRAM_IDX_W];
        rd_left     <= rd_i.arlen;
      end else if (rd_i.rvalid && rd_i.rready) begin
        if (rd_left == '0) begin
          rd_i.rvalid <= 1'b0;
        end else begin
          rd_left <= rd_left - 1'b1;
          rd_idx  <= rd_idx + 1'b1; // All bursts run as INCR.
        end
      end

      if (wr_i.awvalid && wr_i.awready) begin
        wr_busy <= 1'b1;
        wr_idx  <= wr_i.awaddr[soc_map_pkg::SRAM_IDX_LSB +: soc_map_pkg::SRAM_IDX_W];
      end else if (wr_i.wvalid && wr_i.wready) begin
        wr_idx <= wr_idx + 1'b1;
        if (wr_i.wlast) begin
          wr_busy     <= 1'b0;
          wr_i.bvalid <= 1'b1;
        end
      end

      if (wr_i.bvalid && wr_i.bready) begin
        wr_i.bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_i.arvalid && rd_i.arready) begin
      rd_i.rid <= rd_i.arid;
    end
    if (wr_i.awvalid && wr_i.awready) begin
      wr_i.bid <= wr_i.awid;
    end
    if (wr_i.wvalid && wr_i.wready) begin
      for (int b = 0; b < axi_pkg::STRB_W; b++) begin
        if (wr_i.wstrb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_i.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== clint.sv ====
`timescale 1ns/100ps

module clint (
  input  logic   clock,
  input  logic   reset,
  axi_rd_if.slv  rd_i
);

  logic [63:0] mtime;
  logic        busy;
  logic [soc_map_pkg::CLINT_OFF_W-1:0] offset;

  assign offset = rd_i.araddr[soc_map_pkg::CLINT_OFF_W-1:0];

  assign rd_i.arready = !busy;
  assign rd_i.rvalid  = busy;
  assign rd_i.rlast   = busy; // Every answer is a single beat.

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy <= 1'b0;
    end else if (rd_i.arvalid && rd_i.arready) begin
      busy <= 1'b1;
    end else if (rd_i.rvalid && rd_i.rready) begin
      busy <= 1'b0;
    end
  end

  // Response is captured at the AR transfer and held until taken.
  always_ff @(posedge clock) begin
    if (rd_i.arvalid && rd_i.arready) begin
      rd_i.rid <= rd_i.arid;
      case (offset)
        soc_map_pkg::MTIME_OFF: begin
          rd_i.rdata <= mtime;
          rd_i.rresp <= axi_pkg::RESP_OKAY;
        end
        soc_map_pkg::MTIMECMP_OFF: begin
          rd_i.rdata <= soc_map_pkg::MTIMECMP_RESET; // Not writable.
          rd_i.rresp <= axi_pkg::RESP_OKAY;
        end
        default: begin
          rd_i.rdata <= '0;
          rd_i.rresp <= axi_pkg::RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

// ==== mem_subsystem_assertions.sv ====
`timescale 1ns/100ps

module mem_subsystem_assertions (
  input logic                     clock,
  input logic                     reset,
  input logic [axi_pkg::ST_W-1:0] state_i,
  input logic                     ifu_rvalid_i,
  input logic                     exu_rvalid_i,
  input logic                     mem_arvalid_i,
  input logic                     mem_awvalid_i,
  input logic                     mem_wvalid_i,
  input logic                     clint_arvalid_i
);

  logic in_post;

  assign in_post = (state_i == axi_pkg::ARB_IFU_RD_POST) ||
                   (state_i == axi_pkg::ARB_EXU_RD_POST) ||
                   (state_i == axi_pkg::ARB_CLINT_RD_POST) ||
                   (state_i == axi_pkg::ARB_EXU_WR_POST);

  rvalid_exclusive: assert property (@(posedge clock) disable iff (!reset)
    !(ifu_rvalid_i && exu_rvalid_i))
    else $error("IFU and EXU rvalid high in the same cycle");

  idle_quiet: assert property (@(posedge clock) disable iff (!reset)
    (state_i == axi_pkg::ARB_IDLE) |->
      !(mem_arvalid_i || mem_awvalid_i || mem_wvalid_i || clint_arvalid_i))
    else $error("Routed valid high while the arbiter is idle");

  ar_one_target: assert property (@(posedge clock) disable iff (!reset)
    !(mem_arvalid_i && clint_arvalid_i))
    else $error("SRAM and CLINT arvalid high together");

  post_to_idle: assert property (@(posedge clock) disable iff (!reset)
    in_post |=> (state_i == axi_pkg::ARB_IDLE))
    else $error("Arbiter left a POST state for a state other than IDLE");

endmodule

bind axi_arbiter mem_subsystem_assertions asrt0 (
  .clock           (clock),
  .reset           (reset),
  .state_i         (state),
  .ifu_rvalid_i    (ifu_i.rvalid),
  .exu_rvalid_i    (exu_rd_i.rvalid),
  .mem_arvalid_i   (mem_rd_o.arvalid),
  .mem_awvalid_i   (mem_wr_o.awvalid),
  .mem_wvalid_i    (mem_wr_o.wvalid),
  .clint_arvalid_i (clint_rd_o.arvalid)
);

// ==== mem_subsystem_top.sv ====
`timescale 1ns/100ps

module mem_subsystem_top (
  input  logic                         clock,
  input  logic                         reset,

  input  logic                         ifu_arvalid_i,
  input  logic [axi_pkg::ADDR_W-1:0]   ifu_araddr_i,
  input  logic [axi_pkg::ID_W-1:0]     ifu_arid_i,
  input  logic [axi_pkg::LEN_W-1:0]    ifu_arlen_i,
  input  logic [axi_pkg::SIZE_W-1:0]   ifu_arsize_i,
  input  logic [axi_pkg::BURST_W-1:0]  ifu_arburst_i,
  input  logic                         ifu_rready_i,
  output logic                         ifu_arready_o,
  output logic                         ifu_rvalid_o,
  output logic [axi_pkg::DATA_W-1:0]   ifu_rdata_o,
  output logic [axi_pkg::RESP_W-1:0]   ifu_rresp_o,
  output logic                         ifu_rlast_o,
  output logic [axi_pkg::ID_W-1:0]     ifu_rid_o,

  input  logic                         exu_arvalid_i,
  input  logic [axi_pkg::ADDR_W-1:0]   exu_araddr_i,
  input  logic [axi_pkg::ID_W-1:0]     exu_arid_i,
  input  logic [axi_pkg::LEN_W-1:0]    exu_arlen_i,
  input  logic [axi_pkg::SIZE_W-1:0]   exu_arsize_i,
  input  logic [axi_pkg::BURST_W-1:0]  exu_arburst_i,
  input  logic                         exu_rready_i,
  output logic                         exu_arready_o,
  output logic                         exu_rvalid_o,
  output logic [axi_pkg::DATA_W-1:0]   exu_rdata_o,
  output logic [axi_pkg::RESP_W-1:0]   exu_rresp_o,
  output logic                         exu_rlast_o,
  output logic [axi_pkg::ID_W-1:0]     exu_rid_o,

  input  logic                         exu_awvalid_i,
  input  logic [axi_pkg::ADDR_W-1:0]   exu_awaddr_i,
  input  logic [axi_pkg::ID_W-1:0]     exu_awid_i,
  input  logic [axi_pkg::LEN_W-1:0]    exu_awlen_i,
  input  logic [axi_pkg::SIZE_W-1:0]   exu_awsize_i,
  input  logic [axi_pkg::BURST_W-1:0]  exu_awburst_i,
  input  logic                         exu_wvalid_i,
  input  logic [axi_pkg::DATA_W-1:0]   exu_wdata_i,
  input  logic [axi_pkg::STRB_W-1:0]   exu_wstrb_i,
  input  logic                         exu_wlast_i,
  input  logic                         exu_bready_i,
  output logic                         exu_awready_o,
  output logic                         exu_wready_o,
  output logic                         exu_bvalid_o,
  output logic [axi_pkg::RESP_W-1:0]   exu_bresp_o,
  output logic [axi_pkg::ID_W-1:0]     exu_bid_o
);

  axi_rd_if ifu_rd ();
  axi_rd_if exu_rd ();
  axi_wr_if exu_wr ();
  axi_rd_if mem_rd ();
  axi_wr_if mem_wr ();
  axi_rd_if clint_rd ();

  assign ifu_rd.arvalid = ifu_arvalid_i;
  assign ifu_rd.araddr  = ifu_araddr_i;
  assign ifu_rd.arid    = ifu_arid_i;
  assign ifu_rd.arlen   = ifu_arlen_i;
  assign ifu_rd.arsize  = ifu_arsize_i;
  assign ifu_rd.arburst = ifu_arburst_i;
  assign ifu_rd.rready  = ifu_rready_i;
  assign ifu_arready_o  = ifu_rd.arready;
  assign ifu_rvalid_o   = ifu_rd.rvalid;
  assign ifu_rdata_o    = ifu_rd.rdata;
  assign ifu_rresp_o    = ifu_rd.rresp;
  assign ifu_rlast_o    = ifu_rd.rlast;
  assign ifu_rid_o      = ifu_rd.rid;

  assign exu_rd.arvalid = exu_arvalid_i;
  assign exu_rd.araddr  = exu_araddr_i;
  assign exu_rd.arid    = exu_arid_i;
  assign exu_rd.arlen   = exu_arlen_i;
  assign exu_rd.arsize  = exu_arsize_i;
  assign exu_rd.arburst = exu_arburst_i;
  assign exu_rd.rready  = exu_rready_i;
  assign exu_arready_o  = exu_rd.arready;
  assign exu_rvalid_o   = exu_rd.rvalid;
  assign exu_rdata_o    = exu_rd.rdata;
  assign exu_rresp_o    = exu_rd.rresp;
  assign exu_rlast_o    = exu_rd.rlast;
  assign exu_rid_o      = exu_rd.rid;

  assign exu_wr.awvalid = exu_awvalid_i;
  assign exu_wr.awaddr  = exu_awaddr_i;
  assign exu_wr.awid    = exu_awid_i;
  assign exu_wr.awlen   = exu_awlen_i;
  assign exu_wr.awsize  = exu_awsize_i;
  assign exu_wr.awburst = exu_awburst_i;
  assign exu_wr.wvalid  = exu_wvalid_i;
  assign exu_wr.wdata   = exu_wdata_i;
  assign exu_wr.wstrb   = exu_wstrb_i;
  assign exu_wr.wlast   = exu_wlast_i;
  assign exu_wr.bready  = exu_bready_i;
  assign exu_awready_o  = exu_wr.awready;
  assign exu_wready_o   = exu_wr.wready;
  assign exu_bvalid_o   = exu_wr.bvalid;
  assign exu_bresp_o    = exu_wr.bresp;
  assign exu_bid_o      = exu_wr.bid;

  axi_arbiter arbiter0 (
    .clock      (clock),
    .reset      (reset),
    .ifu_i      (ifu_rd),
    .exu_rd_i   (exu_rd),
    .exu_wr_i   (exu_wr),
    .mem_rd_o   (mem_rd),
    .mem_wr_o   (mem_wr),
    .clint_rd_o (clint_rd)
  );

  clint clint0 (
    .clock (clock),
    .reset (reset),
    .rd_i  (clint_rd)
  );

  axi_sram sram0 (
    .clock (clock),
    .reset (reset),
    .rd_i  (mem_rd),
    .wr_i  (mem_wr)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsystem -f sources.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 || echo "Build or simulation ended with an error"
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

// ==== soc_map_pkg.sv ====
package soc_map_pkg;

  // CLINT window decoded on the EXU read path only.
  localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [31:0] CLINT_LAST = 32'h0200_ffff;

  localparam int CLINT_OFF_W = 16; // Offset bits inside the window.

  localparam logic [CLINT_OFF_W-1:0] MTIMECMP_OFF = 16'h4000;
  localparam logic [CLINT_OFF_W-1:0] MTIME_OFF    = 16'hbff8;

  localparam logic [63:0] MTIMECMP_RESET = {64{1'b1}};

  // SRAM takes every address outside the CLINT window.
  localparam int SRAM_WORDS   = 256;
  localparam int SRAM_IDX_W   = $clog2(SRAM_WORDS);
  localparam int SRAM_IDX_LSB = 3; // Word index is address bits 10 down to 3.

endpackage

// ==== sources.f ====
axi_pkg.sv
soc_map_pkg.sv
axi_ifs.sv
axi_arbiter.sv
clint.sv
axi_sram.sv
mem_subsystem_top.sv
mem_subsystem_assertions.sv
tb_mem_subsystem.sv

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/100ps

module tb_mem_subsystem;

  logic clock;
  logic reset;

  logic ifu_arvalid_i, ifu_rready_i, ifu_arready_o, ifu_rvalid_o, ifu_rlast_o;
  logic exu_arvalid_i, exu_rready_i, exu_arready_o, exu_rvalid_o, exu_rlast_o;
  logic exu_awvalid_i, exu_wvalid_i, exu_wlast_i, exu_bready_i;
  logic exu_awready_o, exu_wready_o, exu_bvalid_o;
  logic [31:0] ifu_araddr_i, exu_araddr_i, exu_awaddr_i;
  logic [63:0] ifu_rdata_o, exu_rdata_o, exu_wdata_i;
  logic [7:0]  ifu_arlen_i, exu_arlen_i, exu_awlen_i, exu_wstrb_i;
  logic [3:0]  ifu_arid_i, ifu_rid_o, exu_arid_i, exu_rid_o, exu_awid_i, exu_bid_o;
  logic [2:0]  ifu_arsize_i, exu_arsize_i, exu_awsize_i;
  logic [1:0]  ifu_arburst_i, exu_arburst_i, exu_awburst_i;
  logic [1:0]  ifu_rresp_o, exu_rresp_o, exu_bresp_o;

  logic [63:0] model [256]; // Expected SRAM contents.
  logic [63:0] wbuf_data [256];
  logic [7:0]  wbuf_strb [256];
  logic [31:0] seed;
  int cycles = 0;
  int ifu_first_t, ifu_last_t, exu_first_t, exu_last_t;

  mem_subsystem_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Tests take about 600 cycles.
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= 2000) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic fill_wbuf(input int beats, input bit full);
    logic [31:0] r;
    for (int b = 0; b < beats; b++) begin
      wbuf_data[b] = {next_rand(), next_rand()};
      r = next_rand();
      wbuf_strb[b] = full ? 8'hff : r[7:0];
    end
  endtask

  task automatic write_burst(input logic [31:0] addr, input logic [3:0] id, input int beats);
    logic [7:0] widx;
    widx = addr[10:3];
    @(posedge clock);
    exu_awvalid_i <= 1'b1;
    exu_awaddr_i  <= addr;
    exu_awid_i    <= id;
    exu_awlen_i   <= 8'(beats - 1);
    do @(negedge clock); while (!exu_awready_o);
    @(posedge clock);
    exu_awvalid_i <= 1'b0;
    for (int b = 0; b < beats; b++) begin
      exu_wvalid_i <= 1'b1;
      exu_wdata_i  <= wbuf_data[b];
      exu_wstrb_i  <= wbuf_strb[b];
      exu_wlast_i  <= (b == beats - 1);
      do @(negedge clock); while (!exu_wready_o);
      for (int k = 0; k < 8; k++) begin
        if (wbuf_strb[b][k]) model[8'(widx + b)][k*8 +: 8] = wbuf_data[b][k*8 +: 8];
      end
      @(posedge clock);
    end
    exu_wvalid_i <= 1'b0;
    exu_wlast_i  <= 1'b0;
    exu_bready_i <= 1'b1;
    do @(negedge clock); while (!exu_bvalid_o);
    check("exu_bresp_o", 64'(exu_bresp_o), 64'(axi_pkg::RESP_OKAY));
    check("exu_bid_o", 64'(exu_bid_o), 64'(id));
    @(posedge clock);
    exu_bready_i <= 1'b0;
  endtask

  task automatic drive_r(input bit from_ifu, input logic arvalid, input logic rready);
    if (from_ifu) begin
      ifu_arvalid_i <= arvalid;
      ifu_rready_i  <= rready;
    end else begin
      exu_arvalid_i <= arvalid;
      exu_rready_i  <= rready;
    end
  endtask

  task automatic grab_r(input bit from_ifu, output logic v, output logic [63:0] d,
                        output logic [1:0] resp, output logic last, output logic [3:0] id);
    v    = from_ifu ? ifu_rvalid_o : exu_rvalid_o;
    d    = from_ifu ? ifu_rdata_o : exu_rdata_o;
    resp = from_ifu ? ifu_rresp_o : exu_rresp_o;
    last = from_ifu ? ifu_rlast_o : exu_rlast_o;
    id   = from_ifu ? ifu_rid_o : exu_rid_o;
  endtask

  // A stall_at beat is held back by a low rready for four cycles.
  task automatic read_burst(input bit from_ifu, input logic [31:0] addr, input logic [3:0] id,
                            input int beats, input int stall_at, input bit vs_model,
                            output logic [63:0] data, output logic [1:0] resp,
                            output int ar_cycle);
    logic [7:0]  ridx;
    logic        v;
    logic        last;
    logic [3:0]  rid;
    logic [63:0] held;
    string       pfx;
    ridx = addr[10:3];
    pfx  = from_ifu ? "ifu" : "exu";
    @(posedge clock);
    if (from_ifu) begin
      ifu_araddr_i <= addr;
      ifu_arid_i   <= id;
      ifu_arlen_i  <= 8'(beats - 1);
    end else begin
      exu_araddr_i <= addr;
      exu_arid_i   <= id;
      exu_arlen_i  <= 8'(beats - 1);
    end
    drive_r(from_ifu, 1'b1, 1'b0);
    do @(negedge clock); while (!(from_ifu ? ifu_arready_o : exu_arready_o));
    ar_cycle = cycles;
    @(posedge clock);
    drive_r(from_ifu, 1'b0, 1'b1);
    for (int b = 0; b < beats; b++) begin
      if (b == stall_at) begin
        drive_r(from_ifu, 1'b0, 1'b0);
        do begin
          @(negedge clock);
          grab_r(from_ifu, v, held, resp, last, rid);
        end while (!v);
        repeat (4) begin
          @(negedge clock);
          grab_r(from_ifu, v, data, resp, last, rid);
          check({pfx, "_rvalid_o"}, 64'(v), 64'd1);
          check({pfx, "_rdata_o"}, data, held);
        end
        @(posedge clock);
        drive_r(from_ifu, 1'b0, 1'b1);
      end
      do begin
        @(negedge clock);
        grab_r(from_ifu, v, data, resp, last, rid);
      end while (!v);
      if (vs_model) begin
        check({pfx, "_rdata_o"}, data, model[8'(ridx + b)]);
        check({pfx, "_rresp_o"}, 64'(resp), 64'(axi_pkg::RESP_OKAY));
      end
      check({pfx, "_rid_o"}, 64'(rid), 64'(id));
      check({pfx, "_rlast_o"}, 64'(last), 64'(b == beats - 1));
      if (from_ifu) begin
        if (b == 0) ifu_first_t = cycles;
        ifu_last_t = cycles;
      end else begin
        if (b == 0) exu_first_t = cycles;
        exu_last_t = cycles;
      end
      @(posedge clock);
    end
    drive_r(from_ifu, 1'b0, 1'b0);
  endtask

  task automatic write_merge();
    logic [63:0] d;
    logic [1:0]  r;
    int          c;
    fill_wbuf(4, 1'b1);
    write_burst(32'h8000_0200, 4'h3, 4);
    fill_wbuf(4, 1'b1);
    wbuf_strb[2] = 8'h5a; // Unstrobed bytes keep the first write.
    write_burst(32'h8000_0200, 4'h4, 4);
    read_burst(1'b0, 32'h8000_0200, 4'h5, 4, -1, 1'b1, d, r, c);
  endtask

  task automatic ifu_burst_read();
    logic [63:0] d;
    logic [1:0]  r;
    int          c;
    read_burst(1'b1, 32'h8000_0040, 4'h2, 8, -1, 1'b1, d, r, c);
  endtask

  task automatic fixed_priority();
    logic [63:0] d1;
    logic [63:0] d2;
    logic [1:0]  r1;
    logic [1:0]  r2;
    int          c1;
    int          c2;
    fork
      read_burst(1'b1, 32'h8000_0400, 4'h1, 4, -1, 1'b1, d1, r1, c1);
      read_burst(1'b0, 32'h8000_0600, 4'h2, 4, -1, 1'b1, d2, r2, c2);
    join
    check("ifu_done_before_exu", 64'(ifu_last_t < exu_first_t), 64'd1);
  endtask

  task automatic clint_reads();
    logic [63:0] d;
    logic [63:0] t1;
    logic [63:0] t2;
    logic [1:0]  r;
    int          c1;
    int          c2;
    read_burst(1'b0, soc_map_pkg::CLINT_BASE + 32'h4000, 4'h6, 1, -1, 1'b0, d, r, c1);
    check("exu_rdata_o", d, 64'hffff_ffff_ffff_ffff);
    check("exu_rresp_o", 64'(r), 64'(axi_pkg::RESP_OKAY));
    read_burst(1'b0, soc_map_pkg::CLINT_BASE + 32'hbff8, 4'h7, 1, -1, 1'b0, t1, r, c1);
    check("exu_rresp_o", 64'(r), 64'(axi_pkg::RESP_OKAY));
    repeat (5) @(posedge clock);
    read_burst(1'b0, soc_map_pkg::CLINT_BASE + 32'hbff8, 4'h8, 1, -1, 1'b0, t2, r, c2);
    check("mtime_advance", 64'((t2 - t1) >= 64'(c2 - c1)), 64'd1);
    read_burst(1'b0, soc_map_pkg::CLINT_BASE + 32'h0100, 4'h9, 1, -1, 1'b0, d, r, c1);
    check("exu_rresp_o", 64'(r), 64'(axi_pkg::RESP_SLVERR));
    check("exu_rdata_o", d, 64'd0);
    read_burst(1'b1, 32'h8000_0200, 4'ha, 4, -1, 1'b1, d, r, c1); // SRAM untouched.
  endtask

  task automatic rready_stall();
    logic [63:0] d1;
    logic [63:0] d2;
    logic [1:0]  r1;
    logic [1:0]  r2;
    int          c1;
    int          c2;
    fork
      read_burst(1'b0, 32'h8000_0100, 4'hb, 8, 3, 1'b1, d1, r1, c1);
      begin
        do @(negedge clock); while (!exu_rvalid_o);
        read_burst(1'b1, 32'h8000_0300, 4'hc, 4, -1, 1'b1, d2, r2, c2);
      end
    join
    check("ifu_after_exu", 64'(ifu_first_t > exu_last_t), 64'd1);
  endtask

  task automatic random_pairs();
    logic [31:0] r;
    logic [31:0] addr;
    logic [63:0] d;
    logic [1:0]  rs;
    int          beats;
    int          c;
    for (int i = 0; i < 8; i++) begin
      r     = next_rand();
      addr  = 32'h8000_0000 | {21'd0, r[10:3], 3'd0};
      beats = int'(r[13:11]) + 1;
      fill_wbuf(beats, 1'b0);
      write_burst(addr, 4'(i), beats);
      read_burst(i[0], addr, 4'(i + 8), beats, -1, 1'b1, d, rs, c); // Alternate readers.
    end
  endtask

  initial begin
    seed = 32'h3bda179b;
    reset <= 1'b0;
    ifu_arvalid_i <= 1'b0;
    ifu_araddr_i  <= '0;
    ifu_arid_i    <= '0;
    ifu_arlen_i   <= '0;
    ifu_arsize_i  <= 3'd3;
    ifu_arburst_i <= axi_pkg::BURST_INCR;
    ifu_rready_i  <= 1'b0;
    exu_arvalid_i <= 1'b0;
    exu_araddr_i  <= '0;
    exu_arid_i    <= '0;
    exu_arlen_i   <= '0;
    exu_arsize_i  <= 3'd3;
    exu_arburst_i <= axi_pkg::BURST_INCR;
    exu_rready_i  <= 1'b0;
    exu_awvalid_i <= 1'b0;
    exu_awaddr_i  <= '0;
    exu_awid_i    <= '0;
    exu_awlen_i   <= '0;
    exu_awsize_i  <= 3'd3;
    exu_awburst_i <= axi_pkg::BURST_INCR;
    exu_wvalid_i  <= 1'b0;
    exu_wdata_i   <= '0;
    exu_wstrb_i   <= '0;
    exu_wlast_i   <= 1'b0;
    exu_bready_i  <= 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    fill_wbuf(256, 1'b1);
    write_burst(32'h8000_0000, 4'h0, 256); // Whole SRAM gets known data.
    write_merge();
    ifu_burst_read();
    fixed_priority();
    clint_reads();
    rready_stall();
    random_pairs();
    @(posedge clock);
    $display("RESULT: PASS");
    $finish;
  end

endmodule
